// ==== verilog.f ====
+incdir+src
src/jtframe_dl_pkg.sv
src/jtframe_dl_fifo_if.sv
src/jtframe_spi_rx.sv
src/jtframe_dl_fifo.sv
src/jtframe_ioctl_seq.sv
src/jtframe_data_io.sv
sim/tb_data_io.sv

// ==== sim/tb_data_io.sv ====
// testbench for the ROM download path, drives SPI frames and checks ioctl writes against a model
`timescale 1ns/1ps
`include "jtframe_dl_defines.svh"

module tb_data_io import jtframe_dl_pkg::*; ();

   // frames sent by the main sequence below
   localparam int N_FRAMES     = 14;
   localparam int MAX_FRAME_B  = 41;           // opcode plus up to 40 payload bytes
   localparam int BYTE_CYCLES  = 16 * 8;       // 16 half periods of 8 clk_rom cycles
   localparam int FRAME_EXTRA  = 140;          // select setup, gap and drain wait
   localparam int LIMIT_CYCLES = N_FRAMES * (MAX_FRAME_B * BYTE_CYCLES + FRAME_EXTRA) + 1000;

   logic      clk_rom = 1'b0;
   logic      reset_i;
   logic      sck_i;
   logic      ss_i;
   logic      sdi_i;
   dl_addr_t  ioctl_addr_o;
   dl_byte_t  ioctl_data_o;
   logic      ioctl_wr_o;
   logic      downloading_o;
   dl_index_t index_o;

   logic [15:0] lfsr = 16'd2743;
   int          errors  = 0;
   int          n_writes = 0;

   // reference model
   logic        model_dl  = 1'b0;
   dl_index_t   model_idx = '0;
   dl_addr_t    model_addr = '0;
   dl_addr_t    exp_addr_q [$];
   dl_byte_t    exp_data_q [$];

   jtframe_data_io i_dut (
      .clk_rom       ( clk_rom       ),
      .reset_i       ( reset_i       ),
      .sck_i         ( sck_i         ),
      .ss_i          ( ss_i          ),
      .sdi_i         ( sdi_i         ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_wr_o    ( ioctl_wr_o    ),
      .downloading_o ( downloading_o ),
      .index_o       ( index_o       )
   );

   always #5 clk_rom = ~clk_rom;

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_byte(input string name, input dl_byte_t exp, input dl_byte_t act);
      if (exp !== act) begin
         errors++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input dl_addr_t exp, input dl_addr_t act);
      if (exp !== act) begin
         errors++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_index(input string name, input dl_index_t exp, input dl_index_t act);
      if (exp !== act) begin
         errors++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         errors++;
         $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   // inputs change 1 ns after the rising edge
   task automatic hold_cycles(input int n);
      repeat (n) @(posedge clk_rom);
      #1;
   endtask

   // MSB first, sdi set while sck is low
   task automatic send_byte(input dl_byte_t b);
      for (int i = 7; i >= 0; i--) begin
         sdi_i = b[i];
         sck_i = 1'b0;
         hold_cycles(8);
         sck_i = 1'b1;
         hold_cycles(8);
      end
   endtask

   task automatic open_frame();
      sck_i = 1'b0;
      ss_i  = 1'b0;
      hold_cycles(4);
   endtask

   task automatic close_frame();
      int gap;
      gap   = 4 + take_bits(5);
      sck_i = 1'b0;
      hold_cycles(4);
      ss_i  = 1'b1;
      hold_cycles(gap);
   endtask

   task automatic index_frame();
      dl_index_t v;
      v = take_bits(8);
      open_frame();
      send_byte(`DL_OP_FILE_IDX);
      send_byte(v);
      close_frame();
      model_idx = v;
   endtask

   task automatic transfer_frame(input logic start);
      open_frame();
      send_byte(`DL_OP_FILE_TX);
      send_byte({7'd0, start});
      close_frame();
      model_dl = start;
      if (start) begin
         model_addr = '0;
      end
   endtask

   task automatic data_frame();
      int       len;
      dl_byte_t b;
      len = 1 + (take_bits(6) % 40);
      open_frame();
      send_byte(`DL_OP_FILE_DAT);
      for (int i = 0; i < len; i++) begin
         b = take_bits(8);
         if (model_dl) begin
            exp_addr_q.push_back(model_addr);
            exp_data_q.push_back(b);
            model_addr++;
         end
         send_byte(b);
      end
      close_frame();
   endtask

   // any opcode outside the three known ones
   task automatic unknown_frame();
      dl_byte_t op;
      int       len;
      op = take_bits(8);
      while (op >= `DL_OP_FILE_TX && op <= `DL_OP_FILE_IDX) begin
         op = take_bits(8);
      end
      len = 1 + (take_bits(6) % 40);
      open_frame();
      send_byte(op);
      for (int i = 0; i < len; i++) begin
         send_byte(take_bits(8));
      end
      close_frame();
   endtask

   // pending writes must land within a few cycles of the frame end
   task automatic wait_for_strobes();
      int n;
      n = 0;
      while (exp_data_q.size() != 0 && n < 64) begin
         hold_cycles(1);
         n++;
      end
      if (exp_data_q.size() != 0) begin
         errors++;
         $display("at %0t: %0d expected ioctl_wr_o strobes never came", $time,
                  exp_data_q.size());
         exp_addr_q.delete();
         exp_data_q.delete();
      end
   endtask

   task automatic check_state();
      wait_for_strobes();
      check_bit("downloading_o", model_dl, downloading_o);
      check_index("index_o", model_idx, index_o);
   endtask

   // write monitor, sampled mid cycle
   always @(negedge clk_rom) begin
      if (!reset_i && ioctl_wr_o === 1'b1) begin
         n_writes++;
         if (exp_data_q.size() == 0) begin
            errors++;
            $display("at %0t: unexpected ioctl_wr_o strobe, no write was due", $time);
         end else begin
            check_addr("ioctl_addr_o", exp_addr_q.pop_front(), ioctl_addr_o);
            check_byte("ioctl_data_o", exp_data_q.pop_front(), ioctl_data_o);
         end
      end
   end

   initial begin
      #(LIMIT_CYCLES * 10);
      $display("timeout, run still going after %0d clk_rom cycles", LIMIT_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      reset_i = 1'b1;
      sck_i   = 1'b0;
      ss_i    = 1'b1;
      sdi_i   = 1'b0;
      hold_cycles(4);
      reset_i = 1'b0;
      hold_cycles(2);

      // idle state out of reset
      check_bit("ioctl_wr_o", 1'b0, ioctl_wr_o);
      check_bit("downloading_o", 1'b0, downloading_o);
      check_index("index_o", '0, index_o);
      check_addr("ioctl_addr_o", '0, ioctl_addr_o);

      index_frame();
      check_state();
      transfer_frame(1'b1);
      check_state();
      repeat (3) begin
         data_frame();             // addresses run on across frames
         check_state();
      end
      unknown_frame();
      check_state();
      data_frame();
      check_state();
      transfer_frame(1'b0);
      check_state();
      data_frame();                // outside a download, no writes
      check_state();
      index_frame();
      check_state();
      transfer_frame(1'b1);        // addresses back to 0
      check_state();
      repeat (2) begin
         data_frame();
         check_state();
      end
      transfer_frame(1'b0);
      check_state();

      hold_cycles(8);
      $display("%0d errors, %0d writes seen", errors, n_writes);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== src/jtframe_data_io.sv ====
// ROM download top level, SPI pins in and memory loader strobes out, all in clk_rom
`timescale 1ns/1ps

module jtframe_data_io import jtframe_dl_pkg::*; (
   input  logic      clk_rom,
   input  logic      reset_i,
   // SPI from the io controller
   input  logic      sck_i,
   input  logic      ss_i,          // active low
   input  logic      sdi_i,
   // memory loader
   output dl_addr_t  ioctl_addr_o,
   output dl_byte_t  ioctl_data_o,
   output logic      ioctl_wr_o,
   output logic      downloading_o,
   output dl_index_t index_o
);

   logic     rx_push;
   dl_byte_t rx_byte;
   logic     rx_first;

   jtframe_dl_fifo_if fifo_if ();

   jtframe_spi_rx u_rx (
      .clk_rom       ( clk_rom       ),
      .reset_i       ( reset_i       ),
      .sck_i         ( sck_i         ),
      .ss_i          ( ss_i          ),
      .sdi_i         ( sdi_i         ),
      .push_o        ( rx_push       ),
      .byte_o        ( rx_byte       ),
      .first_o       ( rx_first      )
   );

   jtframe_dl_fifo u_fifo (
      .clk_rom       ( clk_rom       ),
      .reset_i       ( reset_i       ),
      .push_i        ( rx_push       ),
      .byte_i        ( rx_byte       ),
      .first_i       ( rx_first      ),
      .rd            ( fifo_if       )
   );

   jtframe_ioctl_seq u_seq (
      .clk_rom       ( clk_rom       ),
      .reset_i       ( reset_i       ),
      .rd            ( fifo_if       ),
      .ioctl_addr_o  ( ioctl_addr_o  ),
      .ioctl_data_o  ( ioctl_data_o  ),
      .ioctl_wr_o    ( ioctl_wr_o    ),
      .downloading_o ( downloading_o ),
      .index_o       ( index_o       )
   );

endmodule

// ==== src/jtframe_ioctl_seq.sv ====
// opcode decoder and download sequencer, drives the memory loader outputs from FIFO bytes
`timescale 1ns/1ps
`include "jtframe_dl_defines.svh"

module jtframe_ioctl_seq import jtframe_dl_pkg::*; (
   input  logic                     clk_rom,
   input  logic                     reset_i,
   jtframe_dl_fifo_if.consumer      rd,
   output dl_addr_t                 ioctl_addr_o,
   output dl_byte_t                 ioctl_data_o,
   output logic                     ioctl_wr_o,
   output logic                     downloading_o,
   output dl_index_t                index_o
);

   dl_seq_state_t st;
   dl_seq_state_t ret_st;      // where to go after the gap
   dl_byte_t      head_byte;
   logic          head_first;
   logic          data_ok;     // frame carries file data

   assign {head_first, head_byte} = rd.word;

   // at most one pop every other cycle
   assign rd.pop = (st != ST_GAP) && !rd.empty;

   always_ff @(posedge clk_rom) begin
      if (reset_i) begin
         st            <= ST_OPCODE;
         ret_st        <= ST_OPCODE;
         data_ok       <= 1'b0;
         ioctl_wr_o    <= 1'b0;
         downloading_o <= 1'b0;
         ioctl_addr_o  <= '0;
         index_o       <= '0;
      end else begin
         ioctl_wr_o <= 1'b0;
         if (ioctl_wr_o) begin
            ioctl_addr_o <= ioctl_addr_o + 1'b1;   // after the strobe
         end
         if (st == ST_GAP) begin
            st <= ret_st;
         end else if (rd.pop) begin
            st <= ST_GAP;
            if (head_first) begin
               // any flagged byte restarts decoding
               data_ok <= 1'b0;
               case (head_byte)
                  `DL_OP_FILE_TX:  ret_st <= ST_TX_ARG;
                  `DL_OP_FILE_IDX: ret_st <= ST_IDX_ARG;
                  `DL_OP_FILE_DAT: begin
                     ret_st  <= ST_DATA;
                     data_ok <= 1'b1;
                  end
                  default:         ret_st <= ST_DATA;   // unknown, drop the frame
               endcase
            end else begin
               case (st)
                  ST_TX_ARG: begin
                     downloading_o <= head_byte[0];     // 1 starts, 0 ends
                     if (head_byte[0]) begin
                        ioctl_addr_o <= '0;
                     end
                     ret_st <= ST_OPCODE;
                  end
                  ST_IDX_ARG: begin
                     index_o <= head_byte;
                     ret_st  <= ST_OPCODE;
                  end
                  ST_DATA: begin
                     if (data_ok && downloading_o) begin
                        ioctl_wr_o <= 1'b1;
                     end
                     ret_st <= ST_DATA;
                  end
                  default: ret_st <= ST_OPCODE;         // stray byte, ignored
               endcase
            end
         end
      end
   end

   // data follows every pop, only qualified by the strobe
   always_ff @(posedge clk_rom) begin
      if (rd.pop) begin
         ioctl_data_o <= head_byte;
      end
   end

   // the end argument cannot land inside a strobe cycle
   a_wr_in_download: assert property (
      @(posedge clk_rom) disable iff (reset_i) ioctl_wr_o |-> downloading_o
   ) else $error("ioctl_seq: write strobe outside a download");

endmodule

// ==== src/jtframe_dl_fifo.sv ====
// small byte FIFO between the SPI receiver and the download sequencer
`timescale 1ns/1ps
`include "jtframe_dl_defines.svh"

module jtframe_dl_fifo import jtframe_dl_pkg::*; (
   input  logic                     clk_rom,
   input  logic                     reset_i,
   input  logic                     push_i,
   input  dl_byte_t                 byte_i,
   input  logic                     first_i,
   jtframe_dl_fifo_if.buffer        rd
);

   localparam int DEPTH = 1 << `DL_FIFO_AW;

   dl_fifo_word_t          mem [DEPTH];
   logic [`DL_FIFO_AW-1:0] wr_ptr;
   logic [`DL_FIFO_AW-1:0] rd_ptr;
   logic [`DL_FIFO_AW:0]   count;      // 0 to DEPTH
   logic                   full;

   // count never exceeds DEPTH, so the MSB alone means full
   assign full     = count[`DL_FIFO_AW];
   assign rd.empty = (count == '0);
   assign rd.word  = mem[rd_ptr];

   always_ff @(posedge clk_rom) begin
      if (push_i) begin
         mem[wr_ptr] <= {first_i, byte_i};
      end
   end

   // pointers wrap on their own width
   always_ff @(posedge clk_rom) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, rd.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                   // none, or one in and one out
         endcase
      end
   end

   // bytes arrive every 16+ cycles and drain every 2, so this must hold
   a_no_overflow: assert property (
      @(posedge clk_rom) disable iff (reset_i) push_i |-> !full
   ) else $error("dl_fifo: push while full");

   // the sequencer must look at empty before popping
   a_no_underrun: assert property (
      @(posedge clk_rom) disable iff (reset_i) rd.pop |-> !rd.empty
   ) else $error("dl_fifo: pop while empty");

endmodule

// ==== src/jtframe_spi_rx.sv ====
// oversampling SPI receiver, turns the io controller bit stream into bytes with a frame-start flag
`timescale 1ns/1ps

module jtframe_spi_rx import jtframe_dl_pkg::*; (
   input  logic     clk_rom,
   input  logic     reset_i,
   input  logic     sck_i,
   input  logic     ss_i,      // active low
   input  logic     sdi_i,
   output logic     push_o,    // one cycle per complete byte
   output dl_byte_t byte_o,
   output logic     first_o    // byte opens a select frame
);

   logic [2:0] sck_s;          // two sync stages plus one of history
   logic [1:0] ss_s;
   logic [1:0] sdi_s;
   logic       sck_rise;
   logic       ss_active;
   logic [2:0] bit_cnt;
   logic [6:0] shift_r;        // bits so far, MSB first
   logic       first_armed;

   // sdi_s[1] lines up with sck_s[1]
   assign sck_rise  = sck_s[1] & ~sck_s[2];
   assign ss_active = ~ss_s[1];

   // synchronizers
   always_ff @(posedge clk_rom) begin
      if (reset_i) begin
         sck_s <= '0;
         ss_s  <= '1;          // deselected
         sdi_s <= '0;
      end else begin
         sck_s <= {sck_s[1:0], sck_i};
         ss_s  <= {ss_s[0], ss_i};
         sdi_s <= {sdi_s[0], sdi_i};
      end
   end

   // bit counter and strobe
   always_ff @(posedge clk_rom) begin
      if (reset_i) begin
         bit_cnt     <= '0;
         first_armed <= 1'b1;
         push_o      <= 1'b0;
      end else begin
         push_o <= 1'b0;
         if (!ss_active) begin
            bit_cnt     <= '0;     // frame closed
            first_armed <= 1'b1;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               push_o      <= 1'b1;
               first_armed <= 1'b0;
            end
         end
      end
   end

   // shift register and byte output
   always_ff @(posedge clk_rom) begin
      if (ss_active && sck_rise) begin
         shift_r <= {shift_r[5:0], sdi_s[1]};
         if (bit_cnt == 3'd7) begin
            byte_o  <= {shift_r, sdi_s[1]};
            first_o <= first_armed;
         end
      end
   end

   // eight sck periods per byte, so strobes never touch
   a_push_single: assert property (
      @(posedge clk_rom) disable iff (reset_i) push_o |=> !push_o
   ) else $error("spi_rx: back to back push");

endmodule

// ==== src/jtframe_dl_fifo_if.sv ====
// link from the byte FIFO to the download sequencer, head word shown while not empty
`timescale 1ns/1ps

interface jtframe_dl_fifo_if import jtframe_dl_pkg::*; ();

   logic          pop;     // consumer takes the head entry
   dl_fifo_word_t word;    // head entry, valid while empty is low
   logic          empty;

   modport buffer (
      input  pop,
      output word,
      output empty
   );

   modport consumer (
      output pop,
      input  word,
      input  empty
   );

endinterface

// ==== src/jtframe_dl_pkg.sv ====
// shared types of the ROM download path, imported by the RTL modules and the testbench
`include "jtframe_dl_defines.svh"

package jtframe_dl_pkg;

   typedef logic [7:0]            dl_byte_t;      // one SPI byte
   typedef logic [`DL_ADDR_W-1:0] dl_addr_t;      // memory loader address
   typedef logic [7:0]            dl_index_t;     // file index from the menu

   // frame-start flag in the MSB, byte below it
   typedef logic [8:0]            dl_fifo_word_t;

   // download sequencer
   typedef enum logic [2:0] {
      ST_OPCODE,    // waiting for a flagged byte
      ST_TX_ARG,    // start/end argument next
      ST_IDX_ARG,   // index argument next
      ST_DATA,      // payload, written or dropped
      ST_GAP        // one idle cycle after every pop
   } dl_seq_state_t;

endpackage

// ==== src/jtframe_dl_defines.svh ====
// widths, FIFO depth and opcode values of the ROM download path, include where needed
`ifndef JTFRAME_DL_DEFINES_SVH
`define JTFRAME_DL_DEFINES_SVH

// download address, enough for 8MB of ROM
`define DL_ADDR_W       23

// byte FIFO, depth is 2**DL_FIFO_AW
`define DL_FIFO_AW      3

// opcodes sent by the io controller as the first byte of a frame
`define DL_OP_FILE_TX   8'h53   // start/end of transfer, one arg byte
`define DL_OP_FILE_DAT  8'h54   // file payload
`define DL_OP_FILE_IDX  8'h55   // file index, one arg byte

`endif
